//--- logic/fp16_fmt_pkg.sv
`default_nettype none

package fp16_fmt_pkg;

  // ----------------------------------------
  // binary16 encoding
  // ----------------------------------------
  localparam int EXP_BITS = 5;
  localparam int MAN_BITS = 10;
  localparam int FP_WIDTH = 1 + EXP_BITS + MAN_BITS;
  localparam int BIAS = 15;

  // ----------------------------------------
  // Datapath widths
  // ----------------------------------------
  // Precision counts the implicit bit
  localparam int PREC_BITS = MAN_BITS + 1;
  // Aligned sum holds anchor, addend, guard and round
  localparam int SUM_WIDTH = 3 * PREC_BITS + 4;
  // Lower part of the sum searched for the leading one
  localparam int LOWER_SUM_WIDTH = 2 * PREC_BITS + 3;
  localparam int LZC_WIDTH = 5;
  // Signed internal exponent, room for under- and overflow
  localparam int EXP_WIDTH = EXP_BITS + 2;
  // Covers shifts up to SUM_WIDTH
  localparam int SHAMT_WIDTH = 6;

  // Encoded operand
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp16_t;

  // Canonical quiet NaN, positive with only the quiet bit set
  localparam fp16_t QNAN = '{sign: 1'b0, exponent: '1, mantissa: 10'h200};

endpackage

`default_nettype wire

//--- logic/fp_ctrl_pkg.sv
`default_nettype none

package fp_ctrl_pkg;

  // ----------------------------------------
  // Rounding modes
  // ----------------------------------------
  typedef enum logic [2:0] {
    RNE = 3'd0,  // nearest, ties to even
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4   // nearest, ties away from zero
  } roundmode_e;

  // IEEE exception flags, NV in the MSB
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // Operand class, one-hot except for is_signalling
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

endpackage

`default_nettype wire

//--- logic/fp16_classify.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_classify (
  input  fp16_fmt_pkg::fp16_t   operand_a_i,
  input  fp16_fmt_pkg::fp16_t   operand_b_i,
  output fp_ctrl_pkg::fp_info_t info_a_o,
  output fp_ctrl_pkg::fp_info_t info_b_o,
  output logic                  effective_sub_o,
  output logic                  special_valid_o,
  output fp16_fmt_pkg::fp16_t   special_result_o,
  output fp_ctrl_pkg::status_t  special_status_o
);

  import fp16_fmt_pkg::*;
  import fp_ctrl_pkg::*;

  // Class of one operand from its fields
  function automatic fp_info_t classify(input fp16_t op);
    fp_info_t info;
    logic     exp_zero;
    logic     exp_ones;
    logic     man_zero;
    exp_zero           = (op.exponent == '0);
    exp_ones           = (op.exponent == '1);
    man_zero           = (op.mantissa == '0);
    info.is_normal     = !exp_zero && !exp_ones;
    info.is_subnormal  = exp_zero && !man_zero;
    info.is_zero       = exp_zero && man_zero;
    info.is_inf        = exp_ones && man_zero;
    info.is_nan        = exp_ones && !man_zero;
    // Quiet bit clear means signalling
    info.is_signalling = info.is_nan && !op.mantissa[MAN_BITS-1];
    return info;
  endfunction

  assign info_a_o = classify(operand_a_i);
  assign info_b_o = classify(operand_b_i);

  // Operand signs differ
  assign effective_sub_o = operand_a_i.sign ^ operand_b_i.sign;

  // ----------------------------------------
  // Special cases
  // ----------------------------------------
  always_comb begin
    special_valid_o  = 1'b0;
    special_result_o = QNAN;
    special_status_o = '0;
    if (info_a_o.is_nan || info_b_o.is_nan) begin
      // NaN in, canonical NaN out
      special_valid_o     = 1'b1;
      special_status_o.NV = info_a_o.is_signalling || info_b_o.is_signalling;
    end else if (info_a_o.is_inf && info_b_o.is_inf && effective_sub_o) begin
      // inf - inf is invalid
      special_valid_o     = 1'b1;
      special_status_o.NV = 1'b1;
    end else if (info_a_o.is_inf) begin
      special_valid_o  = 1'b1;
      special_result_o = '{sign: operand_a_i.sign, exponent: '1, mantissa: '0};
    end else if (info_b_o.is_inf) begin
      special_valid_o  = 1'b1;
      special_result_o = '{sign: operand_b_i.sign, exponent: '1, mantissa: '0};
    end
  end

endmodule

`default_nettype wire

//--- logic/fp16_align_add.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_align_add (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  logic                                        valid_i,
  input  fp16_fmt_pkg::fp16_t                         operand_a_i,
  input  fp16_fmt_pkg::fp16_t                         operand_b_i,
  input  fp_ctrl_pkg::fp_info_t                       info_a_i,
  input  fp_ctrl_pkg::fp_info_t                       info_b_i,
  input  logic                                        effective_sub_i,
  input  fp_ctrl_pkg::roundmode_e                     rnd_mode_i,
  input  logic                                        special_valid_i,
  input  fp16_fmt_pkg::fp16_t                         special_result_i,
  input  fp_ctrl_pkg::status_t                        special_status_i,
  output logic                                        valid_o,
  output logic        [fp16_fmt_pkg::SUM_WIDTH-1:0]   sum_o,
  output logic signed [fp16_fmt_pkg::EXP_WIDTH-1:0]   exp_anchor_o,
  output logic signed [fp16_fmt_pkg::EXP_WIDTH-1:0]   exp_diff_o,
  output logic signed [fp16_fmt_pkg::EXP_WIDTH-1:0]   tent_exp_o,
  output logic        [fp16_fmt_pkg::SHAMT_WIDTH-1:0] addend_shamt_o,
  output logic                                        sticky_o,
  output logic                                        sign_o,
  output logic                                        effective_sub_o,
  output fp_ctrl_pkg::roundmode_e                     rnd_mode_o,
  output logic                                        special_valid_o,
  output fp16_fmt_pkg::fp16_t                         special_result_o,
  output fp_ctrl_pkg::status_t                        special_status_o
);

  import fp16_fmt_pkg::*;

  // ----------------------------------------
  // Exponent path
  // ----------------------------------------
  logic signed [EXP_WIDTH-1:0]   exp_a;
  logic signed [EXP_WIDTH-1:0]   exp_b;
  logic signed [EXP_WIDTH-1:0]   exp_anchor;
  logic signed [EXP_WIDTH-1:0]   exp_addend;
  logic signed [EXP_WIDTH-1:0]   exp_diff;
  logic        [SHAMT_WIDTH-1:0] addend_shamt;

  assign exp_a = signed'({2'b00, operand_a_i.exponent});
  assign exp_b = signed'({2'b00, operand_b_i.exponent});

  // Subnormals live at exponent 1; zero anchor pinned to the minimum
  assign exp_anchor = info_a_i.is_zero ? EXP_WIDTH'(2 - BIAS)
                                       : exp_a + EXP_WIDTH'(info_a_i.is_subnormal);
  assign exp_addend = exp_b + EXP_WIDTH'(!info_b_i.is_normal);
  assign exp_diff   = exp_addend - exp_anchor;

  // Right shift of B, saturated at both ends
  always_comb begin
    if (exp_diff <= -(2 * PREC_BITS + 1)) begin
      // B only reaches the sticky bit
      addend_shamt = SHAMT_WIDTH'(SUM_WIDTH);
    end else if (exp_diff <= PREC_BITS + 2) begin
      addend_shamt = SHAMT_WIDTH'(PREC_BITS + 3 - exp_diff);
    end else begin
      // B dominates, A ends up in the sticky bit
      addend_shamt = '0;
    end
  end

  // ----------------------------------------
  // Mantissa alignment and add
  // ----------------------------------------
  logic [PREC_BITS-1:0]           mant_a;
  logic [PREC_BITS-1:0]           mant_b;
  logic [SUM_WIDTH-1:0]           anchor_placed;
  logic [SUM_WIDTH+PREC_BITS-1:0] addend_wide;
  logic [SUM_WIDTH-1:0]           addend_shifted;
  logic                           sticky;
  logic                           carry_in;
  logic [SUM_WIDTH:0]             sum_raw;
  logic [SUM_WIDTH-1:0]           sum;
  logic                           sign;

  assign mant_a = {info_a_i.is_normal, operand_a_i.mantissa};
  assign mant_b = {info_b_i.is_normal, operand_b_i.mantissa};

  // A sits p+2 bits below the top, with guard and round below it
  assign anchor_placed = SUM_WIDTH'(mant_a) << (PREC_BITS + 1);

  // Up to p bits of B fall off the bottom
  assign addend_wide = {mant_b, {SUM_WIDTH{1'b0}}} >> addend_shamt;
  assign sticky      = |addend_wide[PREC_BITS-1:0];

  // Two's complement of B, carry dropped when sticky bits are lost
  assign addend_shifted = effective_sub_i ? ~addend_wide[SUM_WIDTH+PREC_BITS-1:PREC_BITS]
                                          : addend_wide[SUM_WIDTH+PREC_BITS-1:PREC_BITS];
  assign carry_in       = effective_sub_i && !sticky;
  assign sum_raw        = {1'b0, anchor_placed} + {1'b0, addend_shifted}
                          + {{SUM_WIDTH{1'b0}}, carry_in};

  // No carry on subtraction: B was larger, negate
  assign sum = (effective_sub_i && !sum_raw[SUM_WIDTH]) ? -sum_raw[SUM_WIDTH-1:0]
                                                        : sum_raw[SUM_WIDTH-1:0];

  // Sign of A unless the subtraction flipped
  always_comb begin
    if (effective_sub_i) begin
      sign = (sum_raw[SUM_WIDTH] == operand_a_i.sign);
    end else begin
      sign = operand_a_i.sign;
    end
  end

  // ----------------------------------------
  // Stage 1 register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    sum_o            <= sum;
    exp_anchor_o     <= exp_anchor;
    exp_diff_o       <= exp_diff;
    tent_exp_o       <= (exp_diff > 0) ? exp_addend : exp_anchor;
    addend_shamt_o   <= addend_shamt;
    sticky_o         <= sticky;
    sign_o           <= sign;
    effective_sub_o  <= effective_sub_i;
    rnd_mode_o       <= rnd_mode_i;
    special_valid_o  <= special_valid_i;
    special_result_o <= special_result_i;
    special_status_o <= special_status_i;
  end

endmodule

`default_nettype wire

//--- logic/fp16_normalize.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_normalize (
  input  logic        [fp16_fmt_pkg::SUM_WIDTH-1:0]   sum_i,
  input  logic signed [fp16_fmt_pkg::EXP_WIDTH-1:0]   exp_anchor_i,
  input  logic signed [fp16_fmt_pkg::EXP_WIDTH-1:0]   exp_diff_i,
  input  logic signed [fp16_fmt_pkg::EXP_WIDTH-1:0]   tent_exp_i,
  input  logic        [fp16_fmt_pkg::SHAMT_WIDTH-1:0] addend_shamt_i,
  input  logic                                        effective_sub_i,
  input  logic                                        sticky_i,
  output logic        [fp16_fmt_pkg::PREC_BITS:0]     final_mantissa_o,
  output logic signed [fp16_fmt_pkg::EXP_WIDTH-1:0]   final_exponent_o,
  output logic                                        sticky_o,
  output logic                                        tie_bit_o
);

  import fp16_fmt_pkg::*;

  // ----------------------------------------
  // Leading-zero count
  // ----------------------------------------
  logic        [LOWER_SUM_WIDTH-1:0] sum_lower;
  logic        [LZC_WIDTH-1:0]       lzc_cnt;
  logic signed [LZC_WIDTH:0]         lzc_sgn;
  logic                              lzc_empty;

  assign sum_lower = sum_i[LOWER_SUM_WIDTH-1:0];

  // Count down from the MSB until the first one
  always_comb begin
    lzc_cnt   = '0;
    lzc_empty = 1'b1;
    for (int i = LOWER_SUM_WIDTH - 1; i >= 0; i--) begin
      if (lzc_empty) begin
        if (sum_lower[i]) begin
          lzc_empty = 1'b0;
        end else begin
          lzc_cnt = lzc_cnt + 1'b1;
        end
      end
    end
  end

  assign lzc_sgn = signed'({1'b0, lzc_cnt});

  // ----------------------------------------
  // Large normalization shift
  // ----------------------------------------
  logic        [SHAMT_WIDTH-1:0] norm_shamt;
  logic signed [EXP_WIDTH-1:0]   norm_exp;
  logic        [SUM_WIDTH:0]     sum_shifted;

  always_comb begin
    if ((exp_diff_i <= 0) || (effective_sub_i && (exp_diff_i <= 2))) begin
      // Anchor-dominated or cancelling, use the count
      if ((exp_anchor_i - lzc_sgn + 1 >= 0) && !lzc_empty) begin
        norm_shamt = SHAMT_WIDTH'(PREC_BITS + 2 + lzc_cnt);
        norm_exp   = exp_anchor_i - lzc_sgn + 1;
      end else begin
        // Tiny result, stop at the subnormal exponent
        norm_shamt = SHAMT_WIDTH'(PREC_BITS + 2 + exp_anchor_i);
        norm_exp   = '0;
      end
    end else begin
      // B-dominated, undo the alignment
      norm_shamt = addend_shamt_i;
      norm_exp   = tent_exp_i;
    end
  end

  // Top bit catches the carry of the add
  assign sum_shifted = {1'b0, sum_i} << norm_shamt;

  // ----------------------------------------
  // 1-bit correction and sticky
  // ----------------------------------------
  logic [LOWER_SUM_WIDTH-1:0] sum_sticky_bits;

  always_comb begin
    {final_mantissa_o, sum_sticky_bits} = sum_shifted[SUM_WIDTH-1:0];
    final_exponent_o                    = norm_exp;
    if (sum_shifted[SUM_WIDTH]) begin
      // Carry out, move right
      {final_mantissa_o, sum_sticky_bits} = sum_shifted[SUM_WIDTH:1];
      final_exponent_o                    = norm_exp + 1;
    end else if (sum_shifted[SUM_WIDTH-1]) begin
      // Already normalized
      final_exponent_o = norm_exp;
    end else if (norm_exp > 1) begin
      // One short, move left
      {final_mantissa_o, sum_sticky_bits} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
      final_exponent_o                    = norm_exp - 1;
    end else begin
      final_exponent_o = '0;
    end
  end

  assign sticky_o  = (|sum_sticky_bits) || sticky_i;
  // First bit below round, used for the tie after rounding
  assign tie_bit_o = sum_sticky_bits[LOWER_SUM_WIDTH-1];

endmodule

`default_nettype wire

//--- logic/fp16_round.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_round (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic                                      valid_i,
  input  logic                                      sign_i,
  input  logic                                      effective_sub_i,
  input  logic        [fp16_fmt_pkg::PREC_BITS:0]   final_mantissa_i,
  input  logic signed [fp16_fmt_pkg::EXP_WIDTH-1:0] final_exponent_i,
  input  logic                                      sticky_i,
  input  logic                                      tie_bit_i,
  input  fp_ctrl_pkg::roundmode_e                   rnd_mode_i,
  input  logic                                      special_valid_i,
  input  fp16_fmt_pkg::fp16_t                       special_result_i,
  input  fp_ctrl_pkg::status_t                      special_status_i,
  output logic                                      valid_o,
  output fp16_fmt_pkg::fp16_t                       result_o,
  output fp_ctrl_pkg::status_t                      status_o
);

  import fp16_fmt_pkg::*;
  import fp_ctrl_pkg::*;

  localparam int ABS_WIDTH = EXP_BITS + MAN_BITS;

  // ----------------------------------------
  // Pre-round value
  // ----------------------------------------
  logic                 of_before;
  logic [EXP_BITS-1:0]  pre_exp;
  logic [ABS_WIDTH-1:0] pre_abs;
  logic [1:0]           round_sticky;

  // Overflow saturates to max-normal and forces inexact
  assign of_before    = (final_exponent_i >= 2 ** EXP_BITS - 1);
  assign pre_exp      = of_before ? EXP_BITS'(2 ** EXP_BITS - 2)
                                  : final_exponent_i[EXP_BITS-1:0];
  assign pre_abs      = {pre_exp, of_before ? {MAN_BITS{1'b1}}
                                            : final_mantissa_i[MAN_BITS:1]};
  assign round_sticky = of_before ? 2'b11 : {final_mantissa_i[0], sticky_i};

  // ----------------------------------------
  // Rounding
  // ----------------------------------------
  logic                 round_up;
  logic [ABS_WIDTH-1:0] rounded_abs;
  logic                 exact_zero;
  logic                 rounded_sign;

  always_comb begin
    case (rnd_mode_i)
      RNE:     round_up = round_sticky[1] && (round_sticky[0] || pre_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_sticky) && sign_i;
      RUP:     round_up = (|round_sticky) && !sign_i;
      RMM:     round_up = round_sticky[1];
      default: round_up = 1'b0;
    endcase
  end

  // Mantissa carry ripples into the exponent
  assign rounded_abs = pre_abs + ABS_WIDTH'(round_up);

  // Exact zero of a subtraction is -0 only when rounding down
  assign exact_zero   = (pre_abs == '0) && (round_sticky == 2'b00);
  assign rounded_sign = (exact_zero && effective_sub_i) ? (rnd_mode_i == RDN) : sign_i;

  // ----------------------------------------
  // Flags and result selection
  // ----------------------------------------
  logic    of_after;
  logic    tiny;
  logic    inexact;
  fp16_t   regular_result;
  status_t regular_status;

  assign of_after = (rounded_abs[ABS_WIDTH-1:MAN_BITS] == '1);

  // Tiny after rounding; a carry into exponent 1 still counts unless it
  // would have carried with unbounded exponent
  assign tiny = (rounded_abs[ABS_WIDTH-1:MAN_BITS] == '0)
             || ((pre_exp == '0) && (rounded_abs[ABS_WIDTH-1:MAN_BITS] == EXP_BITS'(1))
                 && ((round_sticky != 2'b11)
                     || (!tie_bit_i && ((rnd_mode_i == RNE) || (rnd_mode_i == RMM)))));

  assign inexact = (|round_sticky) || of_before || of_after;

  assign regular_result = {rounded_sign, rounded_abs};
  assign regular_status = '{NV: 1'b0, DZ: 1'b0, OF: of_before || of_after,
                            UF: tiny && inexact, NX: inexact};

  // ----------------------------------------
  // Stage 2 register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    result_o <= special_valid_i ? special_result_i : regular_result;
    status_o <= special_valid_i ? special_status_i : regular_status;
  end

endmodule

`default_nettype wire

//--- logic/fp16_add.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_add (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    valid_i,
  input  fp16_fmt_pkg::fp16_t     operand_a_i,
  input  fp16_fmt_pkg::fp16_t     operand_b_i,
  input  fp_ctrl_pkg::roundmode_e rnd_mode_i,
  output logic                    valid_o,
  output fp16_fmt_pkg::fp16_t     result_o,
  output fp_ctrl_pkg::status_t    status_o
);

  import fp16_fmt_pkg::*;
  import fp_ctrl_pkg::*;

  // ----------------------------------------
  // Classification outputs
  // ----------------------------------------
  fp_info_t info_a;
  fp_info_t info_b;
  logic     effective_sub;
  logic     special_valid;
  fp16_t    special_result;
  status_t  special_status;

  // Stage 1
  logic                    s1_valid;
  logic [SUM_WIDTH-1:0]    s1_sum;
  logic signed [EXP_WIDTH-1:0] s1_exp_anchor;
  logic signed [EXP_WIDTH-1:0] s1_exp_diff;
  logic signed [EXP_WIDTH-1:0] s1_tent_exp;
  logic [SHAMT_WIDTH-1:0]  s1_shamt;
  logic                    s1_sticky;
  logic                    s1_sign;
  logic                    s1_eff_sub;
  roundmode_e              s1_rnd_mode;
  logic                    s1_special_valid;
  fp16_t                   s1_special_result;
  status_t                 s1_special_status;

  // Normalized value
  logic [PREC_BITS:0]          final_mantissa;
  logic signed [EXP_WIDTH-1:0] final_exponent;
  logic                        norm_sticky;
  logic                        tie_bit;

  fp16_classify u_classify (
    .operand_a_i      (operand_a_i),
    .operand_b_i      (operand_b_i),
    .info_a_o         (info_a),
    .info_b_o         (info_b),
    .effective_sub_o  (effective_sub),
    .special_valid_o  (special_valid),
    .special_result_o (special_result),
    .special_status_o (special_status)
  );

  fp16_align_add u_align_add (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .valid_i          (valid_i),
    .operand_a_i      (operand_a_i),
    .operand_b_i      (operand_b_i),
    .info_a_i         (info_a),
    .info_b_i         (info_b),
    .effective_sub_i  (effective_sub),
    .rnd_mode_i       (rnd_mode_i),
    .special_valid_i  (special_valid),
    .special_result_i (special_result),
    .special_status_i (special_status),
    .valid_o          (s1_valid),
    .sum_o            (s1_sum),
    .exp_anchor_o     (s1_exp_anchor),
    .exp_diff_o       (s1_exp_diff),
    .tent_exp_o       (s1_tent_exp),
    .addend_shamt_o   (s1_shamt),
    .sticky_o         (s1_sticky),
    .sign_o           (s1_sign),
    .effective_sub_o  (s1_eff_sub),
    .rnd_mode_o       (s1_rnd_mode),
    .special_valid_o  (s1_special_valid),
    .special_result_o (s1_special_result),
    .special_status_o (s1_special_status)
  );

  fp16_normalize u_normalize (
    .sum_i            (s1_sum),
    .exp_anchor_i     (s1_exp_anchor),
    .exp_diff_i       (s1_exp_diff),
    .tent_exp_i       (s1_tent_exp),
    .addend_shamt_i   (s1_shamt),
    .effective_sub_i  (s1_eff_sub),
    .sticky_i         (s1_sticky),
    .final_mantissa_o (final_mantissa),
    .final_exponent_o (final_exponent),
    .sticky_o         (norm_sticky),
    .tie_bit_o        (tie_bit)
  );

  fp16_round u_round (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .valid_i          (s1_valid),
    .sign_i           (s1_sign),
    .effective_sub_i  (s1_eff_sub),
    .final_mantissa_i (final_mantissa),
    .final_exponent_i (final_exponent),
    .sticky_i         (norm_sticky),
    .tie_bit_i        (tie_bit),
    .rnd_mode_i       (s1_rnd_mode),
    .special_valid_i  (s1_special_valid),
    .special_result_i (s1_special_result),
    .special_status_i (s1_special_status),
    .valid_o          (valid_o),
    .result_o         (result_o),
    .status_o         (status_o)
  );

endmodule

`default_nettype wire

//--- verification/fp16_add_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_add_tb;

  import fp16_fmt_pkg::*;
  import fp_ctrl_pkg::*;

  localparam int          MAX_TXN       = 1024;
  localparam int          RAND_PAIRS    = 150;
  localparam int          LATENCY       = 2;
  localparam int          DRAIN_TIMEOUT = 20;
  localparam logic [31:0] LFSR_SEED     = 32'ha61b3c3d;
  localparam logic [31:0] LFSR_TAPS     = 32'ha3000000;
  // Status patterns, NV DZ OF UF NX from the MSB
  localparam logic [4:0]  ST_NONE       = 5'h00;
  localparam logic [4:0]  ST_NV         = 5'h10;
  localparam logic [4:0]  ST_OF_NX      = 5'h05;

  logic       clk_i;
  logic       arst_n_i;
  logic       valid_i;
  fp16_t      operand_a_i;
  fp16_t      operand_b_i;
  roundmode_e rnd_mode_i;
  logic       valid_o;
  fp16_t      result_o;
  status_t    status_o;

  // ----------------------------------------
  // Scoreboard
  // ----------------------------------------
  logic [15:0] op_a    [MAX_TXN];
  logic [15:0] op_b    [MAX_TXN];
  logic [2:0]  op_mode [MAX_TXN];
  logic        has_exp [MAX_TXN];
  logic [15:0] exp_res [MAX_TXN];
  logic [4:0]  exp_st  [MAX_TXN];
  logic [15:0] got_res [MAX_TXN];
  logic [4:0]  got_st  [MAX_TXN];
  int          id_q[$];
  int          due_q[$];
  int          txn_cnt   = 0;
  int          edge_cnt  = 0;
  int          pulse_cnt = 0;
  int          mon_id;
  int          mon_due;
  logic [31:0] lfsr;

  fp16_add uut (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (valid_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .rnd_mode_i  (rnd_mode_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .status_o    (status_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Rising edges seen so far
  always @(posedge clk_i) begin
    edge_cnt <= edge_cnt + 1;
  end

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  // ----------------------------------------
  // Output monitor, sampled mid-cycle
  // ----------------------------------------
  always @(negedge clk_i) begin
    if (valid_o === 1'b1) begin
      if (id_q.size() == 0) begin
        $display("valid_o went high with no transaction in flight");
        abort_run();
      end else begin
        mon_id  = id_q.pop_front();
        mon_due = due_q.pop_front();
        assert (edge_cnt == mon_due) else begin
          $display("[ERROR] valid_o edge: got %h, expected %h", edge_cnt, mon_due);
          abort_run();
        end
        got_res[mon_id] = result_o;
        got_st[mon_id]  = status_o;
        pulse_cnt++;
        if (has_exp[mon_id]) begin
          assert (result_o == exp_res[mon_id]) else begin
            $display("[ERROR] result_o: got %h, expected %h for %h + %h mode %h",
                     result_o, exp_res[mon_id], op_a[mon_id], op_b[mon_id],
                     op_mode[mon_id]);
            abort_run();
          end
          assert (status_o == exp_st[mon_id]) else begin
            $display("[ERROR] status_o: got %h, expected %h for %h + %h",
                     status_o, exp_st[mon_id], op_a[mon_id], op_b[mon_id]);
            abort_run();
          end
        end
      end
    end else if ((id_q.size() != 0) && (edge_cnt >= due_q[0])) begin
      $display("valid_o stayed low when a result was due");
      abort_run();
    end
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  // Galois LFSR, one step per bit taken
  task automatic draw_bits(input int n, output logic [15:0] val);
    int   i;
    logic out_bit;
    val = '0;
    for (i = 0; i < n; i++) begin
      out_bit = lfsr[0];
      lfsr    = lfsr >> 1;
      if (out_bit) begin
        lfsr = lfsr ^ LFSR_TAPS;
      end
      val = {val[14:0], out_bit};
    end
  endtask

  task automatic issue(input logic [15:0] a, input logic [15:0] b, input roundmode_e mode,
                       input logic chk, input logic [15:0] res, input logic [4:0] st);
    @(posedge clk_i);
    valid_i          <= 1'b1;
    operand_a_i      <= a;
    operand_b_i      <= b;
    rnd_mode_i       <= mode;
    op_a[txn_cnt]    = a;
    op_b[txn_cnt]    = b;
    op_mode[txn_cnt] = mode;
    has_exp[txn_cnt] = chk;
    exp_res[txn_cnt] = res;
    exp_st[txn_cnt]  = st;
    id_q.push_back(txn_cnt);
    // Driven on edge edge_cnt+1, result out LATENCY edges later
    due_q.push_back(edge_cnt + 1 + LATENCY);
    txn_cnt++;
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    valid_i <= 1'b0;
  endtask

  // Same result expected under every rounding mode
  task automatic check_all_modes(input logic [15:0] a, input logic [15:0] b,
                                 input logic [15:0] res, input logic [4:0] st);
    int m;
    for (m = 0; m < 5; m++) begin
      issue(a, b, roundmode_e'(m), 1'b1, res, st);
    end
  endtask

  // Exact zero sum, negative only when rounding down
  task automatic check_cancel(input logic [15:0] a, input logic [15:0] b);
    int m;
    for (m = 0; m < 5; m++) begin
      issue(a, b, roundmode_e'(m), 1'b1, (m == int'(RDN)) ? 16'h8000 : 16'h0000, ST_NONE);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (id_q.size() != 0) begin
      if (waited == DRAIN_TIMEOUT) begin
        $display("Timed out waiting for outstanding results");
        abort_run();
      end else begin
        @(posedge clk_i);
        waited++;
      end
    end
  endtask

  // ----------------------------------------
  // Rules over random groups
  // ----------------------------------------
  // Group order: RNE, RNE swapped, RTZ, RDN, RUP
  task automatic check_random_rules(input int base);
    int          p;
    int          id;
    logic [15:0] up_exp;
    for (p = 0; p < RAND_PAIRS; p++) begin
      id = base + 5 * p;
      assert (got_res[id] == got_res[id + 1]) else begin
        $display("[ERROR] result_o swapped: got %h, expected %h", got_res[id + 1], got_res[id]);
        abort_run();
      end
      assert (got_st[id] == got_st[id + 1]) else begin
        $display("[ERROR] status_o swapped: got %h, expected %h", got_st[id + 1], got_st[id]);
        abort_run();
      end
      // Truncation never grows the magnitude
      assert (got_res[id + 2][14:0] <= got_res[id][14:0]) else begin
        $display("[ERROR] result_o RTZ: got %h, RNE gave %h", got_res[id + 2], got_res[id]);
        abort_run();
      end
      // Inexact puts RUP one encoding step above RDN
      if (got_st[id + 3][0]) begin
        up_exp = got_res[id + 3][15] ? got_res[id + 3] - 16'd1 : got_res[id + 3] + 16'd1;
      end else if (got_res[id + 3][14:0] == 15'h0000) begin
        // Exact zero stays negative only when both operands are -0
        up_exp = {op_a[id + 4][15] & op_b[id + 4][15], 15'h0000};
      end else begin
        up_exp = got_res[id + 3];
      end
      assert (got_res[id + 4] == up_exp) else begin
        $display("[ERROR] result_o RUP: got %h, expected %h", got_res[id + 4], up_exp);
        abort_run();
      end
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [15:0] ra;
    logic [15:0] rb;
    int          p;
    int          rand_base;
    valid_i     = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    rnd_mode_i  = RNE;
    arst_n_i    = 1'b0;
    lfsr        = LFSR_SEED;
    for (p = 0; p < 8; p++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      assert (valid_o === 1'b0) else begin
        $display("[ERROR] valid_o in reset: got %h, expected %h", valid_o, 1'b0);
        abort_run();
      end
    end
    @(posedge clk_i);
    arst_n_i <= 1'b1;
    // Idle cycles, monitor flags any stray valid_o
    repeat (4) @(posedge clk_i);

    // Exact sums, including subnormals
    check_all_modes(16'h3c00, 16'h4000, 16'h4200, ST_NONE);
    check_all_modes(16'h4000, 16'hc200, 16'hbc00, ST_NONE);
    check_all_modes(16'h3c00, 16'h3800, 16'h3e00, ST_NONE);
    check_all_modes(16'h4400, 16'h3c00, 16'h4500, ST_NONE);
    check_all_modes(16'hc000, 16'hc000, 16'hc400, ST_NONE);
    check_all_modes(16'h5640, 16'h4900, 16'h56e0, ST_NONE);
    check_all_modes(16'h0001, 16'h0001, 16'h0002, ST_NONE);
    check_all_modes(16'h03ff, 16'h0001, 16'h0400, ST_NONE);
    check_all_modes(16'h0400, 16'h8001, 16'h03ff, ST_NONE);
    go_idle();

    // Cancellation and signed zeros
    check_cancel(16'h3c00, 16'hbc00);
    check_cancel(16'h0123, 16'h8123);
    check_cancel(16'hc500, 16'h4500);
    check_cancel(16'h0000, 16'h8000);
    check_all_modes(16'h4500, 16'h0000, 16'h4500, ST_NONE);
    check_all_modes(16'h4500, 16'h8000, 16'h4500, ST_NONE);
    check_all_modes(16'h0000, 16'hc200, 16'hc200, ST_NONE);
    check_all_modes(16'h8000, 16'hc200, 16'hc200, ST_NONE);
    check_all_modes(16'h0000, 16'h0000, 16'h0000, ST_NONE);
    check_all_modes(16'h8000, 16'h8000, 16'h8000, ST_NONE);
    go_idle();
    repeat (3) @(posedge clk_i);

    // NaN and infinity operands
    check_all_modes(16'h7e00, 16'h3c00, QNAN, ST_NONE);
    check_all_modes(16'h4000, 16'hfe55, QNAN, ST_NONE);
    check_all_modes(16'h7c01, 16'h3c00, QNAN, ST_NV);
    check_all_modes(16'h3c00, 16'hfd00, QNAN, ST_NV);
    check_all_modes(16'h7e00, 16'h7c01, QNAN, ST_NV);
    check_all_modes(16'h7c00, 16'hfc00, QNAN, ST_NV);
    check_all_modes(16'hfc00, 16'h7c00, QNAN, ST_NV);
    check_all_modes(16'h7c00, 16'h3c00, 16'h7c00, ST_NONE);
    check_all_modes(16'hfc00, 16'h4500, 16'hfc00, ST_NONE);
    check_all_modes(16'h4000, 16'hfc00, 16'hfc00, ST_NONE);
    check_all_modes(16'h7c00, 16'h7c00, 16'h7c00, ST_NONE);

    // Overflow past max-normal
    issue(16'h7bff, 16'h7bff, RNE, 1'b1, 16'h7c00, ST_OF_NX);
    issue(16'h7bff, 16'h7bff, RTZ, 1'b1, 16'h7bff, ST_OF_NX);
    issue(16'hfbff, 16'hfbff, RNE, 1'b1, 16'hfc00, ST_OF_NX);
    issue(16'hfbff, 16'hfbff, RTZ, 1'b1, 16'hfbff, ST_OF_NX);
    go_idle();
    drain();

    // Random operands, one long back-to-back burst
    rand_base = txn_cnt;
    for (p = 0; p < RAND_PAIRS; p++) begin
      draw_bits(16, ra);
      draw_bits(16, rb);
      issue(ra, rb, RNE, 1'b0, '0, '0);
      issue(rb, ra, RNE, 1'b0, '0, '0);
      issue(ra, rb, RTZ, 1'b0, '0, '0);
      issue(ra, rb, RDN, 1'b0, '0, '0);
      issue(ra, rb, RUP, 1'b0, '0, '0);
    end
    go_idle();
    drain();
    check_random_rules(rand_base);

    // One valid_o pulse per issued item
    assert (pulse_cnt == txn_cnt) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("[ERROR] valid_o pulses: got %h, expected %h", pulse_cnt, txn_cnt);
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- project.f
logic/fp16_fmt_pkg.sv
logic/fp_ctrl_pkg.sv
logic/fp16_classify.sv
logic/fp16_align_add.sv
logic/fp16_normalize.sv
logic/fp16_round.sv
logic/fp16_add.sv
verification/fp16_add_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fp16 adder testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --top-module fp16_add_tb \
  -f project.f \
  -o fp16_add_tb_sim

# The pipe keeps a failing run going to the log check
./obj_dir/fp16_add_tb_sim 2>&1 | tee "$LOG"

if grep -q "Verification failed" "$LOG"; then
  echo "Simulation FAILED, see $LOG"
  exit 1
fi

echo "Simulation finished, see $LOG"
